// ==== hdl/sdp_wdma_consts.svh ====
/*
 * write-dma output stage constants
 * widths of command, data and dma request payloads
 * field positions inside command and request packets
 */
`ifndef SDP_WDMA_CONSTS_SVH
`define SDP_WDMA_CONSTS_SVH

// ==============================
// widths
// ==============================
`define SDP_WDMA_ADDR_W       59
`define SDP_WDMA_ADDR_SHIFT   5
`define SDP_WDMA_DMA_ADDR_W   64
`define SDP_WDMA_SIZE_W       13
`define SDP_WDMA_DATA_W       256
`define SDP_WDMA_NUM_FIFO     4
`define SDP_WDMA_FIFO_SEL_W   2
`define SDP_WDMA_CMD_PD_W     74
`define SDP_WDMA_REQ_PD_W     258

// ==============================
// field positions
// ==============================
// command payload, addr sits at bit 0, bit 72 unused
`define SDP_WDMA_CMD_SIZE_LSB     59
`define SDP_WDMA_CMD_CUBE_END_BIT 73
// dma request payload
`define SDP_WDMA_REQ_SIZE_LSB     64
`define SDP_WDMA_REQ_ACK_BIT      77
`define SDP_WDMA_REQ_MASK_BIT     256
`define SDP_WDMA_REQ_TYPE_BIT     257

`endif

// ==== hdl/sdp_wdma_pkg.sv ====
/*
 * write-dma output stage types
 * vector typedefs for address, size, data and fifo selection
 * phase enum of the command/data sequencer
 */
`default_nettype none

`include "sdp_wdma_consts.svh"

package sdp_wdma_pkg;

  // command address, 32-byte units
  typedef logic [`SDP_WDMA_ADDR_W-1:0]     cmd_addr_t;
  // beats minus one
  typedef logic [`SDP_WDMA_SIZE_W-1:0]     cmd_size_t;
  // byte address on the dma port
  typedef logic [`SDP_WDMA_DMA_ADDR_W-1:0] dma_addr_t;
  // one fifo word, also one dma data beat
  typedef logic [`SDP_WDMA_DATA_W-1:0]     fifo_data_t;
  typedef logic [`SDP_WDMA_FIFO_SEL_W-1:0] fifo_sel_t;
  // one bit per data fifo
  typedef logic [`SDP_WDMA_NUM_FIFO-1:0]   fifo_vec_t;
  typedef logic [`SDP_WDMA_REQ_PD_W-1:0]   req_pd_t;

  // cmd packet first, then data beats
  typedef enum logic {
    PHASE_CMD = 1'b0,
    PHASE_DAT = 1'b1
  } wdma_phase_e;

endpackage

`default_nettype wire

// ==== hdl/wdma_cmd_latch.sv ====
/*
 * single-entry command holding register
 * unpacks address, size and cube-end from the command payload
 */
`timescale 1ns/1ps
`default_nettype none

`include "sdp_wdma_consts.svh"

module wdma_cmd_latch (
  input  wire logic                          nvdla_core_clk,
  input  wire logic                          nvdla_core_rstn,
  input  wire logic                          cmd2dat_dma_pvld,
  input  wire logic [`SDP_WDMA_CMD_PD_W-1:0] cmd2dat_dma_pd,
  input  wire logic                          cmd_pop,
  output logic                               cmd2dat_dma_prdy,
  output logic                               cmd_vld,
  output sdp_wdma_pkg::cmd_addr_t            cmd_addr,
  output sdp_wdma_pkg::cmd_size_t            cmd_size,
  output logic                               cmd_cube_end
);

  logic cmd_load;

  // ==============================
  // handshake
  // ==============================
  // free slot, or current entry leaving this cycle
  assign cmd2dat_dma_prdy = cmd_pop | ~cmd_vld;
  assign cmd_load         = cmd2dat_dma_pvld & cmd2dat_dma_prdy;

  // occupancy flag
  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      cmd_vld <= 1'b0;
    end else if (cmd2dat_dma_prdy) begin
      cmd_vld <= cmd2dat_dma_pvld;
    end
  end

  // ==============================
  // payload fields
  // ==============================
  // odd flag at bit 72 is not kept
  always_ff @(posedge nvdla_core_clk) begin
    if (cmd_load) begin
      cmd_addr     <= cmd2dat_dma_pd[`SDP_WDMA_ADDR_W-1:0];
      cmd_size     <= cmd2dat_dma_pd[`SDP_WDMA_CMD_SIZE_LSB +: `SDP_WDMA_SIZE_W];
      cmd_cube_end <= cmd2dat_dma_pd[`SDP_WDMA_CMD_CUBE_END_BIT];
    end
  end

endmodule

`default_nettype wire

// ==== hdl/wdma_beat_seq.sv ====
/*
 * command/data phase control for the write-dma output
 * beat counter, last-beat detect, fifo read steering
 * command pop, layer done and interrupt request
 */
`timescale 1ns/1ps
`default_nettype none

`include "sdp_wdma_consts.svh"

module wdma_beat_seq (
  input  wire logic                    nvdla_core_clk,
  input  wire logic                    nvdla_core_rstn,
  input  wire logic                    cmd_vld,
  input  wire sdp_wdma_pkg::cmd_size_t cmd_size,
  input  wire logic                    cmd_cube_end,
  input  wire logic                    wr_rdy,
  input  wire sdp_wdma_pkg::fifo_vec_t dfifo_rd_pvld,
  input  wire logic                    reg2dp_interrupt_ptr,
  output sdp_wdma_pkg::wdma_phase_e    phase,
  output sdp_wdma_pkg::fifo_sel_t      fifo_sel,
  output logic                         cmd_pop,
  output sdp_wdma_pkg::fifo_vec_t      dfifo_rd_prdy,
  output logic                         dat_vld,
  output logic                         dp2reg_done,
  output logic                         intr_req_pvld,
  output logic                         intr_req_ptr
);

  sdp_wdma_pkg::cmd_size_t beat_count;
  logic                    is_last_beat;
  logic                    cmd_accept;
  logic                    dat_rdy;
  logic                    dat_accept;
  logic                    layer_done;

  // ==============================
  // accept conditions
  // ==============================
  // cmd packet goes out once per command
  assign cmd_accept = (phase == sdp_wdma_pkg::PHASE_CMD) & cmd_vld & wr_rdy;

  // data side ready, independent of fifo valid
  assign dat_rdy    = (phase == sdp_wdma_pkg::PHASE_DAT) & wr_rdy;
  assign dat_accept = dat_vld & dat_rdy;

  // size holds beats minus one
  assign is_last_beat = (beat_count == cmd_size);
  assign cmd_pop      = dat_accept & is_last_beat;

  // ==============================
  // phase machine
  // ==============================
  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      phase <= sdp_wdma_pkg::PHASE_CMD;
    end else if (cmd_accept) begin
      phase <= sdp_wdma_pkg::PHASE_DAT;
    end else if (cmd_pop) begin
      phase <= sdp_wdma_pkg::PHASE_CMD;
    end
  end

  // beat counter, restarts at fifo 0 for every command
  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      beat_count <= '0;
    end else if (dat_accept) begin
      if (is_last_beat) begin
        beat_count <= '0;
      end else begin
        beat_count <= beat_count + 1'b1;
      end
    end
  end

  // ==============================
  // fifo steering
  // ==============================
  // one word per beat, round robin over the four fifos
  assign fifo_sel = beat_count[`SDP_WDMA_FIFO_SEL_W-1:0];
  assign dat_vld  = dfifo_rd_pvld[fifo_sel];

  // ready only to the selected fifo
  always_comb begin
    for (int i = 0; i < `SDP_WDMA_NUM_FIFO; i++) begin
      dfifo_rd_prdy[i] = dat_rdy & (fifo_sel == i[`SDP_WDMA_FIFO_SEL_W-1:0]);
    end
  end

  // ==============================
  // done and interrupt
  // ==============================
  // last beat of a cube
  assign layer_done    = cmd_pop & cmd_cube_end;
  assign intr_req_pvld = layer_done;
  assign intr_req_ptr  = reg2dp_interrupt_ptr;

  // done trails the interrupt by one cycle
  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      dp2reg_done <= 1'b0;
    end else begin
      dp2reg_done <= layer_done;
    end
  end

endmodule

`default_nettype wire

// ==== hdl/wdma_dma_req_mux.sv ====
/*
 * quiet-mode decode and dma write request packing
 * command packet or data packet onto one request port
 */
`timescale 1ns/1ps
`default_nettype none

`include "sdp_wdma_consts.svh"

module wdma_dma_req_mux (
  input  wire sdp_wdma_pkg::wdma_phase_e phase,
  input  wire logic                      cmd_vld,
  input  wire sdp_wdma_pkg::cmd_addr_t   cmd_addr,
  input  wire sdp_wdma_pkg::cmd_size_t   cmd_size,
  input  wire logic                      cmd_cube_end,
  input  wire logic                      dat_vld,
  input  wire sdp_wdma_pkg::fifo_sel_t   fifo_sel,
  input  wire sdp_wdma_pkg::fifo_data_t  dfifo_rd_pd0,
  input  wire sdp_wdma_pkg::fifo_data_t  dfifo_rd_pd1,
  input  wire sdp_wdma_pkg::fifo_data_t  dfifo_rd_pd2,
  input  wire sdp_wdma_pkg::fifo_data_t  dfifo_rd_pd3,
  input  wire logic                      dma_wr_req_rdy,
  input  wire logic                      reg2dp_ew_bypass,
  input  wire logic                      reg2dp_ew_alu_bypass,
  input  wire logic [1:0]                reg2dp_ew_alu_algo,
  input  wire logic                      reg2dp_output_dst,
  output logic                           wr_rdy,
  output logic                           dma_wr_req_vld,
  output sdp_wdma_pkg::req_pd_t          dma_wr_req_pd
);

  logic                     cfg_mode_eql;
  logic                     cfg_mode_pdp;
  logic                     cfg_mode_quiet;
  logic                     cmd_pkt_vld;
  logic                     dat_pkt_vld;
  sdp_wdma_pkg::dma_addr_t  cmd_byte_addr;
  sdp_wdma_pkg::fifo_data_t dat_word;

  // ==============================
  // quiet mode
  // ==============================
  // equal-compare alu with both bypasses off
  assign cfg_mode_eql   = ~reg2dp_ew_bypass & ~reg2dp_ew_alu_bypass &
                          (reg2dp_ew_alu_algo == 2'h3);
  // output goes to pooling, not memory
  assign cfg_mode_pdp   = reg2dp_output_dst;
  assign cfg_mode_quiet = cfg_mode_eql | cfg_mode_pdp;

  // quiet mode swallows requests, fifos keep draining
  assign wr_rdy = cfg_mode_quiet | dma_wr_req_rdy;

  assign cmd_pkt_vld    = (phase == sdp_wdma_pkg::PHASE_CMD) & cmd_vld;
  assign dat_pkt_vld    = (phase == sdp_wdma_pkg::PHASE_DAT) & dat_vld;
  assign dma_wr_req_vld = (cmd_pkt_vld | dat_pkt_vld) & ~cfg_mode_quiet;

  // ==============================
  // payload
  // ==============================
  assign cmd_byte_addr = {cmd_addr, {`SDP_WDMA_ADDR_SHIFT{1'b0}}};

  always_comb begin
    case (fifo_sel)
      2'd0:    dat_word = dfifo_rd_pd0;
      2'd1:    dat_word = dfifo_rd_pd1;
      2'd2:    dat_word = dfifo_rd_pd2;
      default: dat_word = dfifo_rd_pd3;
    endcase
  end

  // top bit tells cmd (0) from data (1)
  always_comb begin
    dma_wr_req_pd = '0;
    if (phase == sdp_wdma_pkg::PHASE_CMD) begin
      dma_wr_req_pd[`SDP_WDMA_DMA_ADDR_W-1:0]                    = cmd_byte_addr;
      dma_wr_req_pd[`SDP_WDMA_REQ_SIZE_LSB +: `SDP_WDMA_SIZE_W] = cmd_size;
      // ack requested at end of cube
      dma_wr_req_pd[`SDP_WDMA_REQ_ACK_BIT]                        = cmd_cube_end;
      dma_wr_req_pd[`SDP_WDMA_REQ_TYPE_BIT]                       = 1'b0;
    end else begin
      dma_wr_req_pd[`SDP_WDMA_DATA_W-1:0]    = dat_word;
      // single atom per beat, mask always set
      dma_wr_req_pd[`SDP_WDMA_REQ_MASK_BIT]  = 1'b1;
      dma_wr_req_pd[`SDP_WDMA_REQ_TYPE_BIT]  = 1'b1;
    end
  end

endmodule

`default_nettype wire

// ==== hdl/wdma_unequal_track.sv ====
/*
 * sticky unequal status for equal-compare mode
 * one flag per data fifo, set by any nonzero word read
 */
`timescale 1ns/1ps
`default_nettype none

`include "sdp_wdma_consts.svh"

module wdma_unequal_track (
  input  wire logic                     nvdla_core_clk,
  input  wire logic                     nvdla_core_rstn,
  input  wire logic                     op_load,
  input  wire sdp_wdma_pkg::fifo_vec_t  dfifo_rd_pvld,
  input  wire sdp_wdma_pkg::fifo_vec_t  dfifo_rd_prdy,
  input  wire sdp_wdma_pkg::fifo_data_t dfifo_rd_pd0,
  input  wire sdp_wdma_pkg::fifo_data_t dfifo_rd_pd1,
  input  wire sdp_wdma_pkg::fifo_data_t dfifo_rd_pd2,
  input  wire sdp_wdma_pkg::fifo_data_t dfifo_rd_pd3,
  output logic                          dp2reg_status_unequal
);

  sdp_wdma_pkg::fifo_data_t rd_word [`SDP_WDMA_NUM_FIFO];
  sdp_wdma_pkg::fifo_vec_t  unequal;

  assign rd_word[0] = dfifo_rd_pd0;
  assign rd_word[1] = dfifo_rd_pd1;
  assign rd_word[2] = dfifo_rd_pd2;
  assign rd_word[3] = dfifo_rd_pd3;

  // ==============================
  // per-fifo sticky flags
  // ==============================
  // cleared at layer start, or-in on each accepted word
  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      unequal <= '0;
    end else if (op_load) begin
      unequal <= '0;
    end else begin
      for (int i = 0; i < `SDP_WDMA_NUM_FIFO; i++) begin
        if (dfifo_rd_pvld[i] & dfifo_rd_prdy[i]) begin
          unequal[i] <= unequal[i] | (|rd_word[i]);
        end
      end
    end
  end

  // any fifo saw a mismatch
  assign dp2reg_status_unequal = |unequal;

endmodule

`default_nettype wire

// ==== hdl/sdp_wdma_dat_out.sv ====
/*
 * write-dma data output stage top level
 * command latch, beat sequencer, request packer, unequal tracker
 */
`timescale 1ns/1ps
`default_nettype none

`include "sdp_wdma_consts.svh"

module sdp_wdma_dat_out (
  input  wire logic                          nvdla_core_clk,
  input  wire logic                          nvdla_core_rstn,
  input  wire logic                          op_load,
  // command queue
  input  wire logic                          cmd2dat_dma_pvld,
  input  wire logic [`SDP_WDMA_CMD_PD_W-1:0] cmd2dat_dma_pd,
  output logic                               cmd2dat_dma_prdy,
  // data fifos
  input  wire sdp_wdma_pkg::fifo_vec_t       dfifo_rd_pvld,
  output sdp_wdma_pkg::fifo_vec_t            dfifo_rd_prdy,
  input  wire sdp_wdma_pkg::fifo_data_t      dfifo_rd_pd0,
  input  wire sdp_wdma_pkg::fifo_data_t      dfifo_rd_pd1,
  input  wire sdp_wdma_pkg::fifo_data_t      dfifo_rd_pd2,
  input  wire sdp_wdma_pkg::fifo_data_t      dfifo_rd_pd3,
  // dma write request
  output logic                               dma_wr_req_vld,
  input  wire logic                          dma_wr_req_rdy,
  output sdp_wdma_pkg::req_pd_t              dma_wr_req_pd,
  // config
  input  wire logic                          reg2dp_ew_bypass,
  input  wire logic                          reg2dp_ew_alu_bypass,
  input  wire logic [1:0]                    reg2dp_ew_alu_algo,
  input  wire logic                          reg2dp_output_dst,
  input  wire logic                          reg2dp_interrupt_ptr,
  // status and interrupt
  output logic                               dp2reg_done,
  output logic                               dp2reg_status_unequal,
  output logic                               intr_req_pvld,
  output logic                               intr_req_ptr
);

  logic                      cmd_vld;
  sdp_wdma_pkg::cmd_addr_t   cmd_addr;
  sdp_wdma_pkg::cmd_size_t   cmd_size;
  logic                      cmd_cube_end;
  logic                      cmd_pop;
  sdp_wdma_pkg::wdma_phase_e phase;
  sdp_wdma_pkg::fifo_sel_t   fifo_sel;
  logic                      dat_vld;
  logic                      wr_rdy;

  // ==============================
  // command holding register
  // ==============================
  wdma_cmd_latch u_cmd_latch (
    .nvdla_core_clk   (nvdla_core_clk),
    .nvdla_core_rstn  (nvdla_core_rstn),
    .cmd2dat_dma_pvld (cmd2dat_dma_pvld),
    .cmd2dat_dma_pd   (cmd2dat_dma_pd),
    .cmd_pop          (cmd_pop),
    .cmd2dat_dma_prdy (cmd2dat_dma_prdy),
    .cmd_vld          (cmd_vld),
    .cmd_addr         (cmd_addr),
    .cmd_size         (cmd_size),
    .cmd_cube_end     (cmd_cube_end)
  );

  // ==============================
  // phase and beat control
  // ==============================
  wdma_beat_seq u_beat_seq (
    .nvdla_core_clk       (nvdla_core_clk),
    .nvdla_core_rstn      (nvdla_core_rstn),
    .cmd_vld              (cmd_vld),
    .cmd_size             (cmd_size),
    .cmd_cube_end         (cmd_cube_end),
    .wr_rdy               (wr_rdy),
    .dfifo_rd_pvld        (dfifo_rd_pvld),
    .reg2dp_interrupt_ptr (reg2dp_interrupt_ptr),
    .phase                (phase),
    .fifo_sel             (fifo_sel),
    .cmd_pop              (cmd_pop),
    .dfifo_rd_prdy        (dfifo_rd_prdy),
    .dat_vld              (dat_vld),
    .dp2reg_done          (dp2reg_done),
    .intr_req_pvld        (intr_req_pvld),
    .intr_req_ptr         (intr_req_ptr)
  );

  // ==============================
  // dma request packing
  // ==============================
  wdma_dma_req_mux u_dma_req_mux (
    .phase                (phase),
    .cmd_vld              (cmd_vld),
    .cmd_addr             (cmd_addr),
    .cmd_size             (cmd_size),
    .cmd_cube_end         (cmd_cube_end),
    .dat_vld              (dat_vld),
    .fifo_sel             (fifo_sel),
    .dfifo_rd_pd0         (dfifo_rd_pd0),
    .dfifo_rd_pd1         (dfifo_rd_pd1),
    .dfifo_rd_pd2         (dfifo_rd_pd2),
    .dfifo_rd_pd3         (dfifo_rd_pd3),
    .dma_wr_req_rdy       (dma_wr_req_rdy),
    .reg2dp_ew_bypass     (reg2dp_ew_bypass),
    .reg2dp_ew_alu_bypass (reg2dp_ew_alu_bypass),
    .reg2dp_ew_alu_algo   (reg2dp_ew_alu_algo),
    .reg2dp_output_dst    (reg2dp_output_dst),
    .wr_rdy               (wr_rdy),
    .dma_wr_req_vld       (dma_wr_req_vld),
    .dma_wr_req_pd        (dma_wr_req_pd)
  );

  // ==============================
  // unequal status
  // ==============================
  wdma_unequal_track u_unequal_track (
    .nvdla_core_clk        (nvdla_core_clk),
    .nvdla_core_rstn       (nvdla_core_rstn),
    .op_load               (op_load),
    .dfifo_rd_pvld         (dfifo_rd_pvld),
    .dfifo_rd_prdy         (dfifo_rd_prdy),
    .dfifo_rd_pd0          (dfifo_rd_pd0),
    .dfifo_rd_pd1          (dfifo_rd_pd1),
    .dfifo_rd_pd2          (dfifo_rd_pd2),
    .dfifo_rd_pd3          (dfifo_rd_pd3),
    .dp2reg_status_unequal (dp2reg_status_unequal)
  );

endmodule

`default_nettype wire

// ==== verification/tb_clk_gen.sv ====
/*
 * testbench clock and reset source
 * 4 ns clock, reset held low for 16 cycles
 */
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen (
  output logic nvdla_core_clk,
  output logic nvdla_core_rstn
);

  // 2 ns half period
  initial begin
    nvdla_core_clk = 1'b0;
    forever #2 nvdla_core_clk = ~nvdla_core_clk;
  end

  // release on a falling edge, away from the sampling edge
  initial begin
    nvdla_core_rstn = 1'b0;
    repeat (16) @(posedge nvdla_core_clk);
    @(negedge nvdla_core_clk);
    nvdla_core_rstn = 1'b1;
  end

endmodule

`default_nettype wire

// ==== verification/tb_sdp_wdma_dat_out.sv ====
/*
 * testbench for the write-dma data output stage
 * command table applied in a loop, four fifo models
 * lfsr stalls on dma ready and fifo valid
 * packet, quiet mode, interrupt, done and unequal checks
 */
`timescale 1ns/1ps
`default_nettype none

`include "sdp_wdma_consts.svh"

module tb_sdp_wdma_dat_out;

  localparam int NUM_ROWS  = 10;
  localparam int ROW_LIMIT = 2000;
  localparam int RST_LIMIT = 100;

  // output configurations
  localparam logic [1:0] MODE_NORMAL = 2'd0;
  localparam logic [1:0] MODE_EQL    = 2'd1;
  localparam logic [1:0] MODE_PDP    = 2'd2;

  typedef struct packed {
    logic [58:0] addr;
    logic [12:0] size;
    logic        cube_end;
    logic [1:0]  mode;
    logic        ptr;
    logic        nonzero;
    logic        stall;
    logic        exp_unequal;
  } row_t;

  logic                          nvdla_core_clk;
  logic                          nvdla_core_rstn;
  logic                          op_load;
  logic                          cmd2dat_dma_pvld;
  logic [`SDP_WDMA_CMD_PD_W-1:0] cmd2dat_dma_pd;
  logic                          cmd2dat_dma_prdy;
  logic [3:0]                    dfifo_rd_pvld;
  logic [3:0]                    dfifo_rd_prdy;
  logic [255:0]                  dfifo_rd_pd [4];
  logic                          dma_wr_req_vld;
  logic                          dma_wr_req_rdy;
  logic [257:0]                  dma_wr_req_pd;
  logic                          reg2dp_ew_bypass;
  logic                          reg2dp_ew_alu_bypass;
  logic [1:0]                    reg2dp_ew_alu_algo;
  logic                          reg2dp_output_dst;
  logic                          reg2dp_interrupt_ptr;
  logic                          dp2reg_done;
  logic                          dp2reg_status_unequal;
  logic                          intr_req_pvld;
  logic                          intr_req_ptr;

  row_t        table_rows [NUM_ROWS];
  logic [31:0] lfsr;
  int          errors;
  int          rows_run;
  logic        timed_out;

  tb_clk_gen u_clk_gen (
    .nvdla_core_clk  (nvdla_core_clk),
    .nvdla_core_rstn (nvdla_core_rstn)
  );

  sdp_wdma_dat_out DUT (
    .nvdla_core_clk        (nvdla_core_clk),
    .nvdla_core_rstn       (nvdla_core_rstn),
    .op_load               (op_load),
    .cmd2dat_dma_pvld      (cmd2dat_dma_pvld),
    .cmd2dat_dma_pd        (cmd2dat_dma_pd),
    .cmd2dat_dma_prdy      (cmd2dat_dma_prdy),
    .dfifo_rd_pvld         (dfifo_rd_pvld),
    .dfifo_rd_prdy         (dfifo_rd_prdy),
    .dfifo_rd_pd0          (dfifo_rd_pd[0]),
    .dfifo_rd_pd1          (dfifo_rd_pd[1]),
    .dfifo_rd_pd2          (dfifo_rd_pd[2]),
    .dfifo_rd_pd3          (dfifo_rd_pd[3]),
    .dma_wr_req_vld        (dma_wr_req_vld),
    .dma_wr_req_rdy        (dma_wr_req_rdy),
    .dma_wr_req_pd         (dma_wr_req_pd),
    .reg2dp_ew_bypass      (reg2dp_ew_bypass),
    .reg2dp_ew_alu_bypass  (reg2dp_ew_alu_bypass),
    .reg2dp_ew_alu_algo    (reg2dp_ew_alu_algo),
    .reg2dp_output_dst     (reg2dp_output_dst),
    .reg2dp_interrupt_ptr  (reg2dp_interrupt_ptr),
    .dp2reg_done           (dp2reg_done),
    .dp2reg_status_unequal (dp2reg_status_unequal),
    .intr_req_pvld         (intr_req_pvld),
    .intr_req_ptr          (intr_req_ptr)
  );

  // ==============================
  // helpers
  // ==============================
  // fibonacci lfsr, taps 32 22 2 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic take_bit(output logic b);
    lfsr = lfsr_step(lfsr);
    b    = lfsr[0];
  endtask

  // fifo word for one beat, tagged with row and beat
  function automatic logic [255:0] beat_word(input int row, input int beat, input logic nonzero);
    logic [255:0] w;
    w = '0;
    if (nonzero) begin
      for (int j = 0; j < 8; j++) begin
        w[j*32 +: 32] = {8'(row + 1), 8'(beat), 8'(j), 8'hc3};
      end
    end
    return w;
  endfunction

  // byte address, size, require_ack, type bit 0
  function automatic logic [257:0] cmd_packet(input row_t r);
    logic [257:0] p;
    p        = '0;
    p[63:0]  = {r.addr, 5'b0};
    p[76:64] = r.size;
    p[77]    = r.cube_end;
    return p;
  endfunction

  // type bit 1, mask bit 1, then the word
  function automatic logic [257:0] data_packet(input int row, input int beat, input logic nonzero);
    return {1'b1, 1'b1, beat_word(row, beat, nonzero)};
  endfunction

  task automatic report_fail(input string msg);
    errors++;
    $display("[FAIL] %0t: %s", $time, msg);
  endtask

  task automatic add_row(input int idx, input logic [58:0] addr, input logic [12:0] size,
                         input logic cube_end, input logic [1:0] mode, input logic ptr,
                         input logic nonzero, input logic stall, input logic exp_unequal);
    table_rows[idx] = {addr, size, cube_end, mode, ptr, nonzero, stall, exp_unequal};
  endtask

  // normal rows rotate through configs that each miss one term of the compare decode
  // pdp also bypasses the ew stage
  task automatic set_mode(input logic [1:0] mode, input int idx);
    logic       ew_byp;
    logic       alu_byp;
    logic [1:0] algo;
    ew_byp  = (mode == MODE_PDP);
    alu_byp = 1'b0;
    algo    = 2'd3;
    if (mode == MODE_NORMAL) begin
      case (idx % 3)
        0:       alu_byp = 1'b1;
        1:       ew_byp  = 1'b1;
        default: algo    = 2'd2;
      endcase
    end
    reg2dp_ew_bypass     <= ew_byp;
    reg2dp_ew_alu_bypass <= alu_byp;
    reg2dp_ew_alu_algo   <= algo;
    reg2dp_output_dst    <= (mode == MODE_PDP);
  endtask

  task automatic pulse_op_load();
    @(posedge nvdla_core_clk);
    op_load <= 1'b1;
    @(posedge nvdla_core_clk);
    op_load <= 1'b0;
    @(negedge nvdla_core_clk);
    if (dp2reg_status_unequal !== 1'b0)
      report_fail("unequal status not cleared by op_load");
  endtask

  // ==============================
  // one command, start to finish
  // ==============================
  task automatic run_row(input int idx);
    row_t         r;
    int           nbeats;
    int           taken [4];
    int           beats;
    int           reqs;
    int           cycles;
    int           hs_beat;
    logic         quiet;
    logic         cmd_sent;
    logic         last_seen;
    logic         finished;
    logic         data_acc;
    logic         b;
    logic [257:0] exp_pd;

    r         = table_rows[idx];
    nbeats    = int'(r.size) + 1;
    quiet     = (r.mode != MODE_NORMAL);
    beats     = 0;
    reqs      = 0;
    cycles    = 0;
    cmd_sent  = 1'b0;
    last_seen = 1'b0;
    finished  = 1'b0;
    for (int i = 0; i < 4; i++)
      taken[i] = 0;

    while (!finished && !timed_out) begin
      @(posedge nvdla_core_clk);
      if (cycles == 0) begin
        set_mode(r.mode, idx);
        reg2dp_interrupt_ptr <= r.ptr;
      end
      cmd2dat_dma_pvld <= !cmd_sent;
      cmd2dat_dma_pd   <= {r.cube_end, idx[0], r.size, r.addr};
      b = 1'b1;
      if (r.stall)
        take_bit(b);
      dma_wr_req_rdy <= b;
      // fifo i holds beats i, i+4, i+8 ...
      for (int i = 0; i < 4; i++) begin
        b = 1'b1;
        if (r.stall)
          take_bit(b);
        dfifo_rd_pvld[i] <= b && (taken[i] * 4 + i < nbeats);
        dfifo_rd_pd[i]   <= beat_word(idx, taken[i] * 4 + i, r.nonzero);
      end

      @(negedge nvdla_core_clk);
      cycles++;
      if (cmd2dat_dma_pvld && cmd2dat_dma_prdy)
        cmd_sent = 1'b1;

      // cycle after the last beat
      if (last_seen) begin
        if (dp2reg_done !== r.cube_end)
          report_fail($sformatf("row %0d done is %b after last beat", idx, dp2reg_done));
        if (cmd2dat_dma_prdy !== 1'b1)
          report_fail($sformatf("row %0d command not popped", idx));
        if (dp2reg_status_unequal !== r.exp_unequal)
          report_fail($sformatf("row %0d unequal is %b", idx, dp2reg_status_unequal));
        if (!quiet && reqs != nbeats + 1)
          report_fail($sformatf("row %0d saw %0d requests", idx, reqs));
        finished = 1'b1;
      end else if (dp2reg_done !== 1'b0) begin
        report_fail($sformatf("row %0d done pulsed early", idx));
      end

      // fifo reads, strictly round robin from fifo 0
      hs_beat = -1;
      for (int i = 0; i < 4; i++) begin
        if (dfifo_rd_pvld[i] && dfifo_rd_prdy[i]) begin
          if (i != beats % 4)
            report_fail($sformatf("row %0d beat %0d read fifo %0d", idx, beats, i));
          hs_beat = beats;
          taken[i]++;
          beats++;
        end
      end
      if (!quiet && !dma_wr_req_rdy && dfifo_rd_prdy != 4'b0)
        report_fail($sformatf("row %0d fifo ready raised under back-pressure", idx));

      // dma requests
      if (quiet && dma_wr_req_vld)
        report_fail($sformatf("row %0d request valid in quiet mode", idx));
      data_acc = !quiet && dma_wr_req_vld && dma_wr_req_rdy && reqs > 0;
      if (!quiet && (hs_beat >= 0) != data_acc)
        report_fail($sformatf("row %0d fifo read and data request out of step", idx));
      if (!quiet && dma_wr_req_vld && dma_wr_req_rdy) begin
        if (reqs == 0)
          exp_pd = cmd_packet(r);
        else
          exp_pd = data_packet(idx, reqs - 1, r.nonzero);
        if (reqs > nbeats)
          report_fail($sformatf("row %0d extra request", idx));
        else if (dma_wr_req_pd !== exp_pd)
          report_fail($sformatf("row %0d request %0d pd %h expected %h",
                                idx, reqs, dma_wr_req_pd, exp_pd));
        reqs++;
      end

      // interrupt only with the last beat of a cube
      if (hs_beat == nbeats - 1) begin
        last_seen = 1'b1;
        if (intr_req_pvld !== r.cube_end)
          report_fail($sformatf("row %0d intr is %b on last beat", idx, intr_req_pvld));
        if (r.cube_end && intr_req_ptr !== r.ptr)
          report_fail($sformatf("row %0d intr ptr is %b", idx, intr_req_ptr));
      end else if (intr_req_pvld !== 1'b0) begin
        report_fail($sformatf("row %0d intr outside last beat", idx));
      end

      if (!r.exp_unequal && dp2reg_status_unequal !== 1'b0)
        report_fail($sformatf("row %0d unequal set by zero data", idx));

      if (cycles >= ROW_LIMIT && !finished) begin
        $display("ERROR: row %0d did not complete within %0d cycles", idx, ROW_LIMIT);
        errors++;
        timed_out = 1'b1;
      end
    end
  endtask

  // ==============================
  // main sequence
  // ==============================
  initial begin
    int wait_cycles;

    errors    = 0;
    rows_run  = 0;
    timed_out = 1'b0;
    lfsr      = 32'h9494;

    op_load              = 1'b0;
    cmd2dat_dma_pvld     = 1'b0;
    cmd2dat_dma_pd       = '0;
    dfifo_rd_pvld        = 4'b0;
    dma_wr_req_rdy       = 1'b0;
    reg2dp_ew_bypass     = 1'b1;
    reg2dp_ew_alu_bypass = 1'b1;
    reg2dp_ew_alu_algo   = 2'd0;
    reg2dp_output_dst    = 1'b0;
    reg2dp_interrupt_ptr = 1'b0;
    for (int i = 0; i < 4; i++)
      dfifo_rd_pd[i] = '0;

    //      row addr                  size    cube mode         ptr  nz   stl  uneq
    add_row(0, 59'h1234567,          13'd0,  1'b0, MODE_NORMAL, 1'b0, 1'b0, 1'b0, 1'b0);
    add_row(1, 59'h0abcdef,          13'd6,  1'b1, MODE_NORMAL, 1'b1, 1'b1, 1'b0, 1'b1);
    add_row(2, 59'h0abcdef,          13'd6,  1'b1, MODE_NORMAL, 1'b1, 1'b1, 1'b1, 1'b1);
    add_row(3, 59'h5a5a5a5a5a5a5a5,  13'd9,  1'b0, MODE_NORMAL, 1'b0, 1'b0, 1'b1, 1'b0);
    add_row(4, 59'h100,              13'd3,  1'b1, MODE_EQL,    1'b0, 1'b0, 1'b1, 1'b0);
    add_row(5, 59'h200,              13'd4,  1'b1, MODE_EQL,    1'b1, 1'b1, 1'b1, 1'b1);
    add_row(6, 59'h300,              13'd2,  1'b0, MODE_PDP,    1'b0, 1'b0, 1'b0, 1'b1);
    add_row(7, 59'h400,              13'd7,  1'b1, MODE_PDP,    1'b0, 1'b0, 1'b1, 1'b0);
    add_row(8, 59'h555,              13'd12, 1'b1, MODE_NORMAL, 1'b0, 1'b1, 1'b1, 1'b1);
    add_row(9, 59'h0,                13'd3,  1'b0, MODE_NORMAL, 1'b1, 1'b0, 1'b0, 1'b0);

    wait_cycles = 0;
    while (nvdla_core_rstn !== 1'b1 && wait_cycles < RST_LIMIT) begin
      @(posedge nvdla_core_clk);
      wait_cycles++;
    end
    if (nvdla_core_rstn !== 1'b1) begin
      $display("ERROR: reset was never released");
      errors++;
      timed_out = 1'b1;
    end else begin
      @(negedge nvdla_core_clk);
      if (cmd2dat_dma_prdy !== 1'b1)
        report_fail("command ready low after reset");
      if (dma_wr_req_vld !== 1'b0 || dp2reg_done !== 1'b0 || intr_req_pvld !== 1'b0)
        report_fail("request, done or intr high after reset");
      if (dp2reg_status_unequal !== 1'b0)
        report_fail("unequal high after reset");
    end

    // rows expecting a clean status start with op_load
    for (int i = 0; i < NUM_ROWS; i++) begin
      if (!timed_out) begin
        if (!table_rows[i].exp_unequal)
          pulse_op_load();
        run_row(i);
        rows_run++;
      end
    end

    $display("rows run: %0d, errors: %0d", rows_run, errors);
    if (errors == 0)
      $display("SIMULATION PASSED");
    else
      $display("SIMULATION FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// ==== tb.f ====
+incdir+hdl
hdl/sdp_wdma_pkg.sv
hdl/wdma_cmd_latch.sv
hdl/wdma_beat_seq.sv
hdl/wdma_dma_req_mux.sv
hdl/wdma_unequal_track.sv
hdl/sdp_wdma_dat_out.sv
verification/tb_clk_gen.sv
verification/tb_sdp_wdma_dat_out.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# compile and run the write-dma testbench with verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/1ps -f tb.f \
  --top-module tb_sdp_wdma_dat_out --Mdir obj_dir -o sim_tb
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

out=$(./obj_dir/sim_tb)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -qx "SIMULATION PASSED"; then
  exit 0
fi
exit 1
